// File: sim.f
common/cpuPkg.sv
logic/alu.sv
logic/memorySystem.sv
processor/controlUnit.sv
processor/registerFile.sv
processor/processor.sv
logic/cpuTop.sv
test/cpuTop_assert.sv
test/cpuTest.sv

// File: run.sh
#!/bin/sh
# compile and run the cpuTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTest -f sim.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: test/cpuTest.sv
`timescale 1ns/1ps

module cpuTest;
    import cpuPkg::*;

    localparam int CYCLE_NS = 4;
    localparam int RESET_CYCLES = 4;
    localparam int TEST_COUNT = 6;
    localparam int MAX_PROGRAM_WORDS = 100;
    localparam int HALT_LIMIT = 2 * MAX_PROGRAM_WORDS;   // cycles allowed per run
    localparam int WATCHDOG_NS = TEST_COUNT * (MAX_PROGRAM_WORDS + HALT_LIMIT + 16) * CYCLE_NS
                                 + 400;

    logic                       clk;
    logic                       reset;
    logic                       loadEnable;
    logic [LOAD_ADDR_WIDTH-1:0] loadAddress;
    logic [WORD_WIDTH-1:0]      loadData;
    logic [WORD_WIDTH-1:0]      pc;
    storeBus_t                  storeBus;
    logic                       halted;

    logic [WORD_WIDTH-1:0] progWords [$];
    logic [WORD_WIDTH-1:0] expAddress [$];
    logic [WORD_WIDTH-1:0] expData [$];
    logic [WORD_WIDTH-1:0] gotAddress [$];
    logic [WORD_WIDTH-1:0] gotData [$];
    logic [31:0]           seed = 32'hcee5;
    int                    errorCount = 0;
    int                    testErrorStart = 0;
    int                    testsRun = 0;
    int                    testsFailed = 0;

    cpuTop u_cpuTop (
        .clk         (clk),
        .reset       (reset),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .pc          (pc),
        .storeBus    (storeBus),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    // store trace, pre-edge values
    always @(posedge clk) begin
        if (!reset && storeBus.write) begin
            gotAddress.push_back(storeBus.address);
            gotData.push_back(storeBus.data);
        end
    end

    function automatic logic [WORD_WIDTH-1:0] nextRandom();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:8];
    endfunction

    function automatic logic [WORD_WIDTH-1:0] encodeReg(opcode_t op, logic [3:0] rd,
                                                        logic [3:0] rs, logic [3:0] rt,
                                                        logic [2:0] funct);
        return {op, 1'b0, rd, rs, rt, 5'b0, funct};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] encodeImm(opcode_t op, logic v, logic [3:0] rd,
                                                        logic [3:0] rs, logic [11:0] imm);
        return {op, v, rd, rs, imm};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] extendImm(logic v, logic [11:0] imm);
        return v ? {{12{imm[11]}}, imm} : {12'b0, imm};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] aluModel(logic [2:0] op, logic [WORD_WIDTH-1:0] a,
                                                       logic [WORD_WIDTH-1:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return a << b[4:0];
            3'd6: return a >> b[4:0];
            default: return b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] cond, logic [WORD_WIDTH-1:0] a,
                                         logic [WORD_WIDTH-1:0] b);
        logic [WORD_WIDTH-1:0] diff;
        logic                  n;
        logic                  z;
        logic                  v;
        diff = a - b;
        n = diff[WORD_WIDTH-1];
        z = diff == '0;
        v = (a[WORD_WIDTH-1] != b[WORD_WIDTH-1]) && (diff[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
        case (cond)
            3'd0: return 1'b1;
            3'd1: return z;
            3'd2: return !z;
            3'd3: return n != v;
            3'd4: return n == v;
            default: return 1'b0;
        endcase
    endfunction

    // PASSB immediate, low three bits double as funct
    function automatic logic [WORD_WIDTH-1:0] setReg(logic [3:0] rd, logic v, logic [11:0] imm);
        logic [11:0] fixed;
        fixed = {imm[11:3], 3'b111};
        progWords.push_back(encodeImm(OP_ALUI, v, rd, 4'd0, fixed));
        return extendImm(v, fixed);
    endfunction

    function automatic void storeAt(logic [3:0] rd, logic [11:0] offset,
                                    logic [WORD_WIDTH-1:0] data);
        progWords.push_back(encodeImm(OP_STORE, 1'b1, rd, 4'd0, offset));
        expAddress.push_back(extendImm(1'b1, offset));    // r0 base
        expData.push_back(data);
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareStores();
        checkValue(32'(gotAddress.size()), 32'(expAddress.size()), "store count");
        for (int i = 0; i < gotAddress.size() && i < expAddress.size(); i++) begin
            checkValue(32'(gotAddress[i]), 32'(expAddress[i]), "store address");
            checkValue(32'(gotData[i]), 32'(expData[i]), "store data");
        end
    endtask

    task automatic beginTest();
        progWords.delete();
        expAddress.delete();
        expData.delete();
        testErrorStart = errorCount;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount > testErrorStart) begin
            testsFailed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    // load under reset, release, wait for HALT
    task automatic runProgram();
        int loadCycles;
        int waited;
        loadCycles = (progWords.size() > RESET_CYCLES) ? progWords.size() : RESET_CYCLES;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < loadCycles; i++) begin
            loadEnable = i < progWords.size();
            loadAddress = LOAD_ADDR_WIDTH'(i);
            loadData = (i < progWords.size()) ? progWords[i] : '0;
            @(negedge clk);
        end
        loadEnable = 1'b0;
        checkValue(32'(pc), 32'd0, "pc under reset");
        checkValue(32'(halted), 32'd0, "halted under reset");
        gotAddress.delete();
        gotData.delete();
        reset = 1'b0;
        waited = 0;
        while (!halted && waited < HALT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            $display("the program did not reach HALT within %0d cycles", HALT_LIMIT);
            errorCount++;
        end else begin
            compareStores();
        end
    endtask

    task automatic testAluOps();
        logic [WORD_WIDTH-1:0] a;
        logic [WORD_WIDTH-1:0] b;
        logic [WORD_WIDTH-1:0] rnd;
        logic [11:0]           imm12;
        logic [11:0]           offset;
        beginTest();
        offset = 12'h100;
        for (int op = 0; op < 8; op++) begin
            rnd = nextRandom();
            a = setReg(4'd1, 1'b1, rnd[11:0]);
            rnd = nextRandom();
            b = setReg(4'd2, 1'b0, rnd[11:0]);
            progWords.push_back(encodeReg(OP_ALU, 4'd3, 4'd1, 4'd2, 3'(op)));
            storeAt(4'd3, offset, aluModel(3'(op), a, b));
            offset = offset + 12'd4;
            imm12 = {rnd[14:6], 3'(op)};
            progWords.push_back(encodeImm(OP_ALUI, 1'b0, 4'd4, 4'd1, imm12));
            storeAt(4'd4, offset, aluModel(3'(op), a, extendImm(1'b0, imm12)));
            offset = offset + 12'd4;
            imm12 = {rnd[23:15], 3'(op)};
            progWords.push_back(encodeImm(OP_ALUI, 1'b1, 4'd5, 4'd1, imm12));
            storeAt(4'd5, offset, aluModel(3'(op), a, extendImm(1'b1, imm12)));
            offset = offset + 12'd4;
        end
        progWords.push_back({OP_HALT, 21'b0});
        runProgram();
        endTest("alu operations");
    endtask

    task automatic testLoadStore();
        logic [WORD_WIDTH-1:0] value;
        logic [WORD_WIDTH-1:0] base;
        logic [WORD_WIDTH-1:0] rnd;
        logic [11:0]           offset;
        beginTest();
        rnd = nextRandom();
        value = setReg(4'd1, 1'b0, rnd[11:0]);
        base = setReg(4'd2, 1'b0, 12'h108);
        offset = 12'hff0;                                  // minus 16
        progWords.push_back(encodeImm(OP_STORE, 1'b1, 4'd1, 4'd2, offset));
        progWords.push_back(encodeImm(OP_LOAD, 1'b1, 4'd3, 4'd2, offset));
        progWords.push_back(encodeImm(OP_STORE, 1'b1, 4'd3, 4'd2, offset));
        progWords.push_back({OP_HALT, 21'b0});
        for (int i = 0; i < 2; i++) begin
            expAddress.push_back(base + extendImm(1'b1, offset));
            expData.push_back(value);
        end
        runProgram();
        endTest("store and load");
    endtask

    task automatic testBranches();
        logic [WORD_WIDTH-1:0] vals [3];
        logic [11:0]           mark;
        int                    pairA [3];
        int                    pairB [3];
        int                    block;
        beginTest();
        vals[0] = '0;
        vals[1] = setReg(4'd1, 1'b0, 12'h007);
        vals[2] = setReg(4'd2, 1'b0, 12'h00f);
        pairA = '{1, 1, 2};
        pairB = '{1, 2, 1};
        block = 0;
        for (int p = 0; p < 3; p++) begin
            for (int cond = 0; cond < 5; cond++) begin
                mark = 12'h200 + 12'(block * 16);
                progWords.push_back(encodeReg(OP_CMP, 4'd0, 4'(pairA[p]), 4'(pairB[p]), 3'd0));
                progWords.push_back({OP_BRANCH, 1'b0, 20'(cond)});    // offset equals cond
                if (branchTaken(3'(cond), vals[pairA[p]], vals[pairB[p]])) begin
                    progWords.push_back(encodeImm(OP_STORE, 1'b1, 4'd1, 4'd0, mark));
                end else begin
                    storeAt(4'd1, mark, vals[1]);
                end
                for (int k = 0; k < cond; k++) begin
                    progWords.push_back({OP_NOP, 21'b0});
                end
                storeAt(4'd1, mark + 12'd8, vals[1]);
                block++;
            end
        end
        progWords.push_back({OP_HALT, 21'b0});
        runProgram();
        endTest("branches");
    endtask

    task automatic testPcRegister();
        logic [WORD_WIDTH-1:0] marker;
        int                    target;
        beginTest();
        progWords.push_back(encodeReg(OP_ALU, 4'd1, 4'd15, 4'd0, 3'(ALU_ADD)));
        marker = WORD_WIDTH'(4 * (progWords.size() - 1) + 8);
        storeAt(4'd1, 12'h080, marker);
        storeAt(4'd15, 12'h084, WORD_WIDTH'(4 * progWords.size() + 8));
        target = progWords.size() + 3;
        if (target % 2 == 0) target++;                      // odd word keeps imm low bits 111
        progWords.push_back(encodeImm(OP_ALUI, 1'b0, 4'd15, 4'd0, 12'(4 * target + 3)));
        while (progWords.size() < target) begin
            progWords.push_back(encodeImm(OP_STORE, 1'b1, 4'd1, 4'd0, 12'h300));
        end
        storeAt(4'd1, 12'h310, marker);
        progWords.push_back({OP_HALT, 21'b0});
        runProgram();
        endTest("r15 read and jump");
    endtask

    task automatic testHalt();
        logic [WORD_WIDTH-1:0] value;
        int                    haltWord;
        beginTest();
        value = setReg(4'd1, 1'b0, 12'h5a7);
        storeAt(4'd1, 12'h040, value);
        haltWord = progWords.size();
        progWords.push_back({OP_HALT, 21'b0});
        progWords.push_back(encodeImm(OP_STORE, 1'b1, 4'd1, 4'd0, 12'h044));
        runProgram();
        checkValue(32'(pc), 32'(4 * haltWord), "pc at HALT");
        repeat (5) @(negedge clk);
        checkValue(32'(pc), 32'(4 * haltWord), "pc after HALT");
        checkValue(32'(halted), 32'd1, "halted level");
        compareStores();
        endTest("halt");
    endtask

    task automatic testSecondReset();
        beginTest();
        storeAt(4'd1, 12'h050, '0);                         // r1 cleared by reset
        progWords.push_back({OP_HALT, 21'b0});
        runProgram();
        endTest("second reset");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        loadEnable = 1'b0;
        loadAddress = '0;
        loadData = '0;
        testAluOps();
        testLoadStore();
        testBranches();
        testPcRegister();
        testHalt();
        testSecondReset();
        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: test/cpuTop_assert.sv
`timescale 1ns/1ps

module cpuTop_assert (
    input logic                          clk,
    input logic                          reset,
    input logic [cpuPkg::WORD_WIDTH-1:0] pc,
    input logic [cpuPkg::WORD_WIDTH-1:0] instruction,
    input cpuPkg::storeBus_t             storeBus,
    input logic                          halted
);
    import cpuPkg::*;

    logic [2:0] op;
    logic       isBranch;
    logic       writesPc;

    assign op = instruction[OPCODE_HI:OPCODE_LO];
    assign isBranch = op == OP_BRANCH;
    assign writesPc = (op == OP_ALU || op == OP_ALUI || op == OP_LOAD) &&
                      instruction[RD_HI:RD_LO] == REG_ADDR_WIDTH'(PC_REG);

    noStoreInReset: assert property (@(posedge clk) reset |-> !storeBus.write)
        else $error("store strobe during reset");

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    pcHeldWhenHalted: assert property (@(posedge clk) disable iff (reset)
        halted |=> pc == $past(pc))
        else $error("pc moved while halted");

    pcSequential: assert property (@(posedge clk) disable iff (reset)
        (!halted && !isBranch && !writesPc) |=> pc == $past(pc) + WORD_WIDTH'(4))
        else $error("pc did not advance by 4");

endmodule

bind cpuTop cpuTop_assert u_cpuTopAssert (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .instruction (instruction),
    .storeBus    (storeBus),
    .halted      (halted)
);

// File: logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                loadEnable,
    input  logic [cpuPkg::LOAD_ADDR_WIDTH-1:0]  loadAddress,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       loadData,
    output logic [cpuPkg::WORD_WIDTH-1:0]       pc,
    output cpuPkg::storeBus_t                   storeBus,
    output logic                                halted
);
    import cpuPkg::*;

    logic [WORD_WIDTH-1:0] instruction;
    logic [WORD_WIDTH-1:0] readData;

    memorySystem #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memorySystem (
        .clk         (clk),
        .reset       (reset),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .pc          (pc),
        .storeBus    (storeBus),
        .instruction (instruction),
        .readData    (readData)
    );

    processor u_processor (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .readData    (readData),
        .pc          (pc),
        .storeBus    (storeBus),
        .halted      (halted)
    );

endmodule

// File: processor/processor.sv
`timescale 1ns/1ps

module processor (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::WORD_WIDTH-1:0]   instruction,
    input  logic [cpuPkg::WORD_WIDTH-1:0]   readData,
    output logic [cpuPkg::WORD_WIDTH-1:0]   pc,
    output cpuPkg::storeBus_t               storeBus,
    output logic                            halted
);
    import cpuPkg::*;

    opcode_t                   opcode;
    logic                      immBit;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [2:0]                funct;
    logic [REG_ADDR_WIDTH-1:0] readAddressB;

    controlSignals_t           control;
    aluFlags_t                 aluFlags;

    logic [WORD_WIDTH-1:0]     pcPlus4;
    logic [WORD_WIDTH-1:0]     pcPlus8;
    logic [WORD_WIDTH-1:0]     nextPc;
    logic [WORD_WIDTH-1:0]     extImm;
    logic [WORD_WIDTH-1:0]     regA;
    logic [WORD_WIDTH-1:0]     regB;
    logic [WORD_WIDTH-1:0]     srcA;
    logic [WORD_WIDTH-1:0]     srcB;
    logic [WORD_WIDTH-1:0]     aluResult;
    logic [WORD_WIDTH-1:0]     result;

    assign opcode = opcode_t'(instruction[OPCODE_HI:OPCODE_LO]);
    assign immBit = instruction[IMM_BIT];
    assign rd     = instruction[RD_HI:RD_LO];
    assign rs     = instruction[RS_HI:RS_LO];
    assign rt     = instruction[RT_HI:RT_LO];
    assign funct  = instruction[FUNCT_HI:FUNCT_LO];

    // stores take their data from Rd, since Rt overlaps the offset
    assign readAddressB = (opcode == OP_STORE) ? rd : rt;

    assign pcPlus4 = pc + WORD_WIDTH'(4);
    assign pcPlus8 = pcPlus4 + WORD_WIDTH'(4);

    always_comb begin
        case (control.immSrc)
            IMM_ZERO12:   extImm = {{(WORD_WIDTH - SHORT_IMM_WIDTH){1'b0}},
                                    instruction[SHORT_IMM_WIDTH-1:0]};
            IMM_SIGN12:   extImm = {{(WORD_WIDTH - SHORT_IMM_WIDTH){instruction[SHORT_IMM_WIDTH-1]}},
                                    instruction[SHORT_IMM_WIDTH-1:0]};
            IMM_SIGN20X4: extImm = {{(WORD_WIDTH - LONG_IMM_WIDTH - 2){instruction[LONG_IMM_WIDTH-1]}},
                                    instruction[LONG_IMM_WIDTH-1:0], 2'b00};
            default:      extImm = '0;
        endcase
    end

    assign srcA   = control.srcAFromPc ? pcPlus8 : regA;
    assign srcB   = control.aluSrc ? extImm : regB;
    assign result = control.memToReg ? readData : aluResult;

    // jump targets are forced to a word boundary
    assign nextPc = halted ? pc :
                    control.pcFromResult ? {result[WORD_WIDTH-1:2], 2'b00} : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign storeBus.write   = control.memWrite;
    assign storeBus.address = aluResult;
    assign storeBus.data    = regB;

    controlUnit u_controlUnit (
        .clk     (clk),
        .reset   (reset),
        .opcode  (opcode),
        .immBit  (immBit),
        .funct   (funct),
        .rd      (rd),
        .flags   (aluFlags),
        .control (control),
        .halted  (halted)
    );

    registerFile u_registerFile (
        .clk          (clk),
        .reset        (reset),
        .readAddressA (rs),
        .readAddressB (readAddressB),
        .writeAddress (rd),
        .writeEnable  (control.regWrite),
        .writeData    (result),
        .pcPlus8      (pcPlus8),
        .readDataA    (regA),
        .readDataB    (regB)
    );

    alu u_alu (
        .a      (srcA),
        .b      (srcB),
        .op     (control.aluControl),
        .result (aluResult),
        .flags  (aluFlags)
    );

endmodule

// File: processor/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [cpuPkg::REG_ADDR_WIDTH-1:0]   readAddressA,
    input  logic [cpuPkg::REG_ADDR_WIDTH-1:0]   readAddressB,
    input  logic [cpuPkg::REG_ADDR_WIDTH-1:0]   writeAddress,
    input  logic                                writeEnable,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       writeData,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       pcPlus8,
    output logic [cpuPkg::WORD_WIDTH-1:0]       readDataA,
    output logic [cpuPkg::WORD_WIDTH-1:0]       readDataB
);
    import cpuPkg::*;

    localparam logic [REG_ADDR_WIDTH-1:0] PC_ADDR = REG_ADDR_WIDTH'(PC_REG);

    logic [WORD_WIDTH-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddress != PC_ADDR) begin
            regs[writeAddress] <= writeData;   // r15 lives in the PC register
        end
    end

    assign readDataA = (readAddressA == PC_ADDR) ? pcPlus8 : regs[readAddressA];
    assign readDataB = (readAddressB == PC_ADDR) ? pcPlus8 : regs[readAddressB];

endmodule

// File: processor/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                                clk,
    input  logic                                reset,
    input  cpuPkg::opcode_t                     opcode,
    input  logic                                immBit,
    input  logic [2:0]                          funct,
    input  logic [cpuPkg::REG_ADDR_WIDTH-1:0]   rd,
    input  cpuPkg::aluFlags_t                   flags,
    output cpuPkg::controlSignals_t             control,
    output logic                                halted
);
    import cpuPkg::*;

    aluFlags_t   flagReg;
    logic        haltedReg;
    branchCond_t cond;
    logic        condHolds;

    assign cond = branchCond_t'(funct);

    always_comb begin
        case (cond)
            COND_ALWAYS: condHolds = 1'b1;
            COND_EQ:     condHolds = flagReg.z;
            COND_NE:     condHolds = !flagReg.z;
            COND_LT:     condHolds = flagReg.n != flagReg.v;
            COND_GE:     condHolds = flagReg.n == flagReg.v;
            default:     condHolds = 1'b0;  // unused codes never branch
        endcase
    end

    always_comb begin
        control            = '0;
        control.aluControl = aluOp_t'(funct);
        control.immSrc     = IMM_SIGN12;
        case (opcode)
            OP_ALU: control.regWrite = 1'b1;
            OP_ALUI: begin
                control.regWrite = 1'b1;
                control.aluSrc   = 1'b1;
                control.immSrc   = immBit ? IMM_SIGN12 : IMM_ZERO12;
            end
            OP_CMP: begin
                control.aluSrc     = immBit;
                control.aluControl = ALU_SUB;
            end
            OP_LOAD: begin
                control.regWrite   = 1'b1;
                control.memToReg   = 1'b1;
                control.aluSrc     = 1'b1;
                control.aluControl = ALU_ADD;
            end
            OP_STORE: begin
                control.memWrite   = !reset;    // no stores while the program loads
                control.aluSrc     = 1'b1;
                control.aluControl = ALU_ADD;
            end
            OP_BRANCH: begin
                control.srcAFromPc = 1'b1;
                control.aluSrc     = 1'b1;
                control.immSrc     = IMM_SIGN20X4;
                control.aluControl = ALU_ADD;
            end
            default: ;                          // HALT and the reserved code
        endcase
        control.pcFromResult = (opcode == OP_BRANCH && condHolds) ||
                               (control.regWrite && rd == REG_ADDR_WIDTH'(PC_REG));
    end

    assign halted = haltedReg || opcode == OP_HALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            flagReg   <= '0;
            haltedReg <= 1'b0;
        end else begin
            if (opcode == OP_CMP) flagReg <= flags;    // only CMP touches NZCV
            if (opcode == OP_HALT) haltedReg <= 1'b1;
        end
    end

endmodule

// File: logic/memorySystem.sv
`timescale 1ns/1ps

module memorySystem #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                loadEnable,
    input  logic [cpuPkg::LOAD_ADDR_WIDTH-1:0]  loadAddress,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       loadData,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       pc,
    input  cpuPkg::storeBus_t                   storeBus,
    output logic [cpuPkg::WORD_WIDTH-1:0]       instruction,
    output logic [cpuPkg::WORD_WIDTH-1:0]       readData
);
    import cpuPkg::*;

    localparam int IMEM_INDEX = $clog2(IMEM_WORDS);
    localparam int DMEM_INDEX = $clog2(DMEM_WORDS);

    logic [WORD_WIDTH-1:0] instrMem [IMEM_WORDS];
    logic [WORD_WIDTH-1:0] dataMem [DMEM_WORDS];

    logic [IMEM_INDEX-1:0] fetchIndex;
    logic [IMEM_INDEX-1:0] loadIndex;
    logic [DMEM_INDEX-1:0] dataIndex;

    // word addressed, upper bits wrap
    assign fetchIndex = pc[IMEM_INDEX+1:2];
    assign loadIndex  = IMEM_INDEX'(loadAddress);
    assign dataIndex  = storeBus.address[DMEM_INDEX+1:2];

    always_ff @(posedge clk) begin
        if (reset && loadEnable) begin
            instrMem[loadIndex] <= loadData;    // program fill only under reset
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && storeBus.write) begin
            dataMem[dataIndex] <= storeBus.data;
        end
    end

    assign instruction = instrMem[fetchIndex];
    assign readData    = dataMem[dataIndex];

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::WORD_WIDTH-1:0]   a,
    input  logic [cpuPkg::WORD_WIDTH-1:0]   b,
    input  cpuPkg::aluOp_t                  op,
    output logic [cpuPkg::WORD_WIDTH-1:0]   result,
    output cpuPkg::aluFlags_t               flags
);
    import cpuPkg::*;

    logic [WORD_WIDTH:0]   sum;        // carry in the top bit
    logic [WORD_WIDTH:0]   diff;       // top bit set means no borrow
    logic [4:0]            shamt;

    assign sum   = {1'b0, a} + {1'b0, b};
    assign diff  = {1'b0, a} + {1'b0, ~b} + (WORD_WIDTH + 1)'(1);
    assign shamt = b[4:0];

    always_comb begin
        flags.c = 1'b0;
        flags.v = 1'b0;
        case (op)
            ALU_ADD: begin
                result  = sum[WORD_WIDTH-1:0];
                flags.c = sum[WORD_WIDTH];
                flags.v = (a[WORD_WIDTH-1] == b[WORD_WIDTH-1]) &&
                          (result[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
            end
            ALU_SUB: begin
                result  = diff[WORD_WIDTH-1:0];
                flags.c = diff[WORD_WIDTH];
                flags.v = (a[WORD_WIDTH-1] != b[WORD_WIDTH-1]) &&
                          (result[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
            end
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_SHL:   result = a << shamt;
            ALU_SHR:   result = a >> shamt;    // logical
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
        flags.n = result[WORD_WIDTH-1];
        flags.z = result == '0;
    end

endmodule

// File: common/cpuPkg.sv
package cpuPkg;

    localparam int WORD_WIDTH = 24;
    localparam int REG_COUNT = 16;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int PC_REG = 15;            // reads PC+8, writes redirect the PC
    localparam int LOAD_ADDR_WIDTH = 8;

    // instruction field layout
    localparam int OPCODE_HI = 23;
    localparam int OPCODE_LO = 21;
    localparam int IMM_BIT = 20;
    localparam int RD_HI = 19;
    localparam int RD_LO = 16;
    localparam int RS_HI = 15;
    localparam int RS_LO = 12;
    localparam int RT_HI = 11;
    localparam int RT_LO = 8;
    localparam int FUNCT_HI = 2;
    localparam int FUNCT_LO = 0;
    localparam int SHORT_IMM_WIDTH = 12;   // ALUI, load and store offset
    localparam int LONG_IMM_WIDTH = 20;    // branch word offset

    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_ALUI   = 3'd1,
        OP_CMP    = 3'd2,
        OP_LOAD   = 3'd3,
        OP_STORE  = 3'd4,
        OP_BRANCH = 3'd5,
        OP_HALT   = 3'd6,
        OP_NOP    = 3'd7                   // reserved
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SHL   = 3'd5,
        ALU_SHR   = 3'd6,
        ALU_PASSB = 3'd7
    } aluOp_t;

    typedef enum logic [2:0] {
        COND_ALWAYS = 3'd0,
        COND_EQ     = 3'd1,
        COND_NE     = 3'd2,
        COND_LT     = 3'd3,
        COND_GE     = 3'd4
    } branchCond_t;

    typedef enum logic [1:0] {
        IMM_ZERO12   = 2'd0,
        IMM_SIGN12   = 2'd1,
        IMM_SIGN20X4 = 2'd2
    } immSrc_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } aluFlags_t;

    typedef struct packed {
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    aluSrc;                   // B from immediate
        logic    pcFromResult;
        logic    srcAFromPc;               // A from PC+8
        immSrc_t immSrc;
        aluOp_t  aluControl;
    } controlSignals_t;

    typedef struct packed {
        logic                  write;
        logic [WORD_WIDTH-1:0] address;
        logic [WORD_WIDTH-1:0] data;
    } storeBus_t;

endpackage
